/* hw/adc_spi_pkg.sv */
package adc_spi_pkg;

	//////////////////////////////////////////////////
	// Frame layout
	//////////////////////////////////////////////////

	// Largest number of converters on one board. This also sets the mask width.
	localparam int MAX_ADC = 8;

	// One serial write is always 32 bits long.
	localparam int FRAME_BITS = 32;

	// The converter expects this pattern ahead of the register address.
	localparam logic [11:0] FRAME_HEADER = 12'b0000_0000_0001;

	//////////////////////////////////////////////////
	// Command and launch records
	//////////////////////////////////////////////////

	// One write request from the host.
	typedef struct packed {
		logic [MAX_ADC-1:0] mask;    // Target converters, one bit each.
		logic [3:0]         addr;    // Converter register address.
		logic [15:0]        data;    // Value to write.
	} adc_cmd_t;

	// What the sequencer hands out for the duration of one write.
	// The lanes shift the frame, and the tracker uses lanes, addr and data
	// to update the shadow copy when every lane is finished.
	typedef struct packed {
		logic [MAX_ADC-1:0]    lanes;    // Effective mask, already trimmed to NUM_ADC.
		logic [3:0]            addr;
		logic [15:0]           data;
		logic [FRAME_BITS-1:0] frame;    // Header, address and data, MSB first.
	} adc_launch_t;

	//////////////////////////////////////////////////
	// State encodings
	//////////////////////////////////////////////////

	typedef enum logic [1:0] {
		SEQ_IDLE   = 2'd0,    // Waiting for a host command.
		SEQ_LAUNCH = 2'd1,    // One cycle that fires launch_start.
		SEQ_WAIT   = 2'd2     // Lanes busy, waiting for all_done.
	} seq_state_t;

	typedef enum logic [1:0] {
		LANE_IDLE  = 2'd0,
		LANE_SHIFT = 2'd1,    // Select low, one bit per cycle.
		LANE_GAP   = 2'd2     // Select high for one cycle before done.
	} lane_state_t;

endpackage

/* hw/cmd_sequencer.sv */
`timescale 1ns/100ps

module cmd_sequencer
	import adc_spi_pkg::*;
#(
	parameter int NUM_ADC = 2
) (
	input  logic        adc0_sclk,
	input  logic        reset,
	input  adc_cmd_t    cmd,
	input  logic        cmd_valid,
	input  logic        all_done,
	output adc_launch_t launch,
	output logic        launch_start,
	output logic        busy,
	output logic        cmd_reject
);

	// Bits of the host mask that point at converters which are fitted.
	localparam logic [MAX_ADC-1:0] PRESENT_MASK = {MAX_ADC{1'b1}} >> (MAX_ADC - NUM_ADC);

	seq_state_t state;
	adc_launch_t launch_q;
	logic [MAX_ADC-1:0] eff_mask;
	logic accept;
	logic empty_cmd;

	//////////////////////////////////////////////////
	// Command qualification
	//////////////////////////////////////////////////

	always_comb begin
		eff_mask = cmd.mask & PRESENT_MASK;    // Drop bits for absent converters.
		empty_cmd = (eff_mask == '0);
		// Commands are only looked at while idle.
		// Anything offered during a write is simply dropped.
		accept = cmd_valid && (state == SEQ_IDLE);
	end

	//////////////////////////////////////////////////
	// Control FSM
	//////////////////////////////////////////////////

	always_ff @(posedge adc0_sclk) begin
		if (reset) begin
			state <= SEQ_IDLE;
			cmd_reject <= 1'b0;
		end else begin
			cmd_reject <= 1'b0;    // Single-cycle pulse.
			case (state)
				SEQ_IDLE: begin
					if (accept) begin
						if (empty_cmd) begin
							cmd_reject <= 1'b1;    // Nothing to send, stay idle.
						end else begin
							state <= SEQ_LAUNCH;
						end
					end
				end
				SEQ_LAUNCH: begin
					state <= SEQ_WAIT;
				end
				SEQ_WAIT: begin
					// The tracker reports once every started lane has finished.
					if (all_done) begin
						state <= SEQ_IDLE;
					end
				end
				default: begin
					state <= SEQ_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Launch record
	//////////////////////////////////////////////////

	// Captured on acceptance and held until the write is over, so the
	// tracker still sees the address and data when it updates the shadow.
	always_ff @(posedge adc0_sclk) begin
		if (accept && !empty_cmd) begin
			launch_q.lanes <= eff_mask;
			launch_q.addr <= cmd.addr;
			launch_q.data <= cmd.data;
			launch_q.frame <= {FRAME_HEADER, cmd.addr, cmd.data};
		end
	end

	assign launch = launch_q;
	assign launch_start = (state == SEQ_LAUNCH);
	assign busy = (state != SEQ_IDLE);

endmodule

/* hw/serial_lane.sv */
`timescale 1ns/100ps

module serial_lane
	import adc_spi_pkg::*;
(
	input  logic        adc0_sclk,
	input  logic        reset,
	input  adc_launch_t launch,
	input  logic        launch_start,
	input  logic        lane_sel,
	output logic        adc_n_scs,
	output logic        adc_sdata,
	output logic        lane_done
);

	localparam logic [4:0] LAST_BIT = 5'(FRAME_BITS - 1);

	lane_state_t state;
	logic [FRAME_BITS-1:0] shift_q;    // Frame, MSB leaves first.
	logic [4:0] bit_idx;               // Bits already put on the line.
	logic done_q;

	//////////////////////////////////////////////////
	// Lane FSM
	//////////////////////////////////////////////////

	always_ff @(posedge adc0_sclk) begin
		if (reset) begin
			state <= LANE_IDLE;
			bit_idx <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				LANE_IDLE: begin
					// Every lane sees the launch, but only selected ones start.
					if (launch_start && lane_sel) begin
						state <= LANE_SHIFT;
						bit_idx <= '0;
					end
				end
				LANE_SHIFT: begin
					bit_idx <= bit_idx + 5'd1;
					if (bit_idx == LAST_BIT) begin
						state <= LANE_GAP;    // Select goes high next cycle.
					end
				end
				LANE_GAP: begin
					state <= LANE_IDLE;
					done_q <= 1'b1;
				end
				default: begin
					state <= LANE_IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Shift register
	//////////////////////////////////////////////////

	// The frame is loaded on the start cycle and moved one place per bit.
	// The converter samples on the rising edge after each bit is set up.
	always_ff @(posedge adc0_sclk) begin
		if (state == LANE_IDLE && launch_start && lane_sel) begin
			shift_q <= launch.frame;
		end else if (state == LANE_SHIFT) begin
			shift_q <= {shift_q[FRAME_BITS-2:0], 1'b0};
		end
	end

	// Select is low for exactly the shift phase.
	assign adc_n_scs = (state != LANE_SHIFT);
	assign adc_sdata = (state == LANE_SHIFT) ? shift_q[FRAME_BITS-1] : 1'b0;    // Quiet low otherwise.
	assign lane_done = done_q;

endmodule

/* hw/shadow_tracker.sv */
`timescale 1ns/100ps

module shadow_tracker
	import adc_spi_pkg::*;
#(
	parameter int NUM_ADC = 2
) (
	input  logic               adc0_sclk,
	input  logic               reset,
	input  adc_launch_t        launch,
	input  logic               launch_start,
	input  logic [NUM_ADC-1:0] lane_done,
	input  logic [2:0]         rd_adc,
	input  logic [3:0]         rd_addr,
	output logic [15:0]        rd_data,
	output logic               all_done,
	output logic               done
);

	logic [NUM_ADC-1:0] pending;    // Lanes that have started and not yet finished.
	logic [NUM_ADC-1:0] pending_next;
	logic finish;
	logic done_q;

	// Last value written to each converter register.
	logic [15:0] shadow [NUM_ADC][16];

	//////////////////////////////////////////////////
	// Completion tracking
	//////////////////////////////////////////////////

	always_comb begin
		pending_next = pending & ~lane_done;
		// The write is over on the cycle the last outstanding bit clears.
		finish = (pending != '0) && (pending_next == '0);
	end

	always_ff @(posedge adc0_sclk) begin
		if (reset) begin
			pending <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= finish;
			if (launch_start) begin
				pending <= launch.lanes[NUM_ADC-1:0];
			end else begin
				pending <= pending_next;
			end
		end
	end

	// The sequencer and the host get the same pulse.
	assign all_done = done_q;
	assign done = done_q;

	//////////////////////////////////////////////////
	// Shadow register file
	//////////////////////////////////////////////////

	// The launch record is still held by the sequencer when the lanes finish,
	// so address and data can be taken straight from it.
	always_ff @(posedge adc0_sclk) begin
		if (reset) begin
			for (int a = 0; a < NUM_ADC; a++) begin
				for (int r = 0; r < 16; r++) begin
					shadow[a][r] <= '0;
				end
			end
		end else if (finish) begin
			for (int a = 0; a < NUM_ADC; a++) begin
				if (launch.lanes[a]) begin
					shadow[a][launch.addr] <= launch.data;
				end
			end
		end
	end

	// Combinational read port. A converter number past NUM_ADC matches
	// nothing and leaves the result at zero.
	always_comb begin
		rd_data = '0;
		for (int a = 0; a < NUM_ADC; a++) begin
			if (rd_adc == 3'(a)) begin
				rd_data = shadow[a][rd_addr];
			end
		end
	end

endmodule

/* hw/adc_spi_ctrl.sv */
`timescale 1ns/100ps

module adc_spi_ctrl
	import adc_spi_pkg::*;
#(
	parameter int NUM_ADC = 2
) (
	input  logic               adc0_sclk,
	input  logic               reset,
	input  adc_cmd_t           cmd,
	input  logic               cmd_valid,
	input  logic [2:0]         rd_adc,
	input  logic [3:0]         rd_addr,
	output logic               busy,
	output logic               cmd_reject,
	output logic               done,
	output logic [15:0]        rd_data,
	output logic [NUM_ADC-1:0] adc_n_scs,
	output logic [NUM_ADC-1:0] adc_sdata
);

	adc_launch_t launch;
	logic launch_start;
	logic all_done;
	logic [NUM_ADC-1:0] lane_done;

	//////////////////////////////////////////////////
	// Command path
	//////////////////////////////////////////////////

	cmd_sequencer #(
		.NUM_ADC(NUM_ADC)
	) i_cmd_sequencer (
		.adc0_sclk   (adc0_sclk),
		.reset       (reset),
		.cmd         (cmd),
		.cmd_valid   (cmd_valid),
		.all_done    (all_done),
		.launch      (launch),
		.launch_start(launch_start),
		.busy        (busy),
		.cmd_reject  (cmd_reject)
	);

	//////////////////////////////////////////////////
	// One serial lane per converter
	//////////////////////////////////////////////////

	// All lanes get the same launch and run in lockstep.
	for (genvar i = 0; i < NUM_ADC; i++) begin : g_lane
		serial_lane i_serial_lane (
			.adc0_sclk   (adc0_sclk),
			.reset       (reset),
			.launch      (launch),
			.launch_start(launch_start),
			.lane_sel    (launch.lanes[i]),    // This converter's own mask bit.
			.adc_n_scs   (adc_n_scs[i]),
			.adc_sdata   (adc_sdata[i]),
			.lane_done   (lane_done[i])
		);
	end

	//////////////////////////////////////////////////
	// Completion and shadow copy
	//////////////////////////////////////////////////

	shadow_tracker #(
		.NUM_ADC(NUM_ADC)
	) i_shadow_tracker (
		.adc0_sclk   (adc0_sclk),
		.reset       (reset),
		.launch      (launch),
		.launch_start(launch_start),
		.lane_done   (lane_done),
		.rd_adc      (rd_adc),
		.rd_addr     (rd_addr),
		.rd_data     (rd_data),
		.all_done    (all_done),
		.done        (done)
	);

endmodule

/* tb/adc_serial_model.sv */
`timescale 1ns/100ps

module adc_serial_model #(
	parameter int ADC_ID = 0
) (
	input  logic        adc0_sclk,
	input  logic        reset,
	input  logic        adc_n_scs,
	input  logic        adc_sdata,
	output logic [31:0] frame,          // Last complete frame, first bit in the MSB.
	output logic [31:0] bit_count,      // Bits seen while select was low for that frame.
	output logic [31:0] frame_count,    // Steps by one each time select rises.
	output logic [31:0] stray_count     // Data seen high while select was high.
);

	logic [31:0] shift_q;
	logic [31:0] count_q;
	logic scs_q;    // Select as seen on the previous edge.

	//////////////////////////////////////////////////
	// Converter side of the serial port
	//////////////////////////////////////////////////

	// Like the real part, data is taken on the rising edge while select is low.
	always_ff @(posedge adc0_sclk) begin
		if (reset) begin
			shift_q <= '0;
			count_q <= '0;
			scs_q <= 1'b1;
			frame <= '0;
			bit_count <= '0;
			frame_count <= '0;
			stray_count <= '0;
		end else begin
			scs_q <= adc_n_scs;
			if (!adc_n_scs) begin
				shift_q <= {shift_q[30:0], adc_sdata};
				count_q <= count_q + 32'd1;
			end else begin
				if (adc_sdata) begin
					stray_count <= stray_count + 32'd1;    // The line should idle low.
				end
				if (!scs_q) begin
					// Select has just risen, so the frame is complete.
					frame <= shift_q;
					bit_count <= count_q;
					frame_count <= frame_count + 32'd1;
					count_q <= '0;
					$display("ADC %0d received frame %h with %0d bits at %0t ns",
						ADC_ID, shift_q, count_q, $time);
				end
			end
		end
	end

endmodule

/* tb/tb_adc_spi_ctrl.sv */
`timescale 1ns/100ps

module tb_adc_spi_ctrl
	import adc_spi_pkg::*;
();

	localparam int NUM_ADC = 2;
	localparam int NUM_ENTRIES = 10;
	localparam int DONE_LATENCY = 36;    // Accepting edge to the edge that sees done.
	localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40 + 100;

	typedef struct packed {
		logic [7:0]  mask;
		logic [3:0]  addr;
		logic [15:0] data;
		logic        rand_data;     // Replace data with the next random value.
		logic        exp_reject;
		logic        poke;          // Offer a second command while busy.
	} stim_t;

	logic adc0_sclk;
	logic reset;
	adc_cmd_t cmd;
	logic cmd_valid;
	logic [2:0] rd_adc;
	logic [3:0] rd_addr;
	logic busy;
	logic cmd_reject;
	logic done;
	logic [15:0] rd_data;
	logic [NUM_ADC-1:0] adc_n_scs;
	logic [NUM_ADC-1:0] adc_sdata;
	logic [31:0] rx_frame [NUM_ADC];
	logic [31:0] rx_bits [NUM_ADC];
	logic [31:0] rx_count [NUM_ADC];
	logic [31:0] rx_stray [NUM_ADC];

	stim_t stim [NUM_ENTRIES];
	logic [15:0] exp_shadow [NUM_ADC][16];    // What each register should hold by now.
	logic [31:0] rng_state;
	int errors;
	int checks;
	int cycle_count;

	adc_spi_ctrl #(
		.NUM_ADC(NUM_ADC)
	) i_adc_spi_ctrl (
		.adc0_sclk (adc0_sclk),
		.reset     (reset),
		.cmd       (cmd),
		.cmd_valid (cmd_valid),
		.rd_adc    (rd_adc),
		.rd_addr   (rd_addr),
		.busy      (busy),
		.cmd_reject(cmd_reject),
		.done      (done),
		.rd_data   (rd_data),
		.adc_n_scs (adc_n_scs),
		.adc_sdata (adc_sdata)
	);

	for (genvar g = 0; g < NUM_ADC; g++) begin : g_model
		adc_serial_model #(
			.ADC_ID(g)
		) i_adc_serial_model (
			.adc0_sclk  (adc0_sclk),
			.reset      (reset),
			.adc_n_scs  (adc_n_scs[g]),
			.adc_sdata  (adc_sdata[g]),
			.frame      (rx_frame[g]),
			.bit_count  (rx_bits[g]),
			.frame_count(rx_count[g]),
			.stray_count(rx_stray[g])
		);
	end

	initial begin
		adc0_sclk = 1'b0;
		forever #4 adc0_sclk = ~adc0_sclk;
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
			input logic [31:0] expected);
		checks++;
		if (actual !== expected) begin
			$display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
			errors++;
		end
	endtask

	task automatic read_shadow(input int adc, input int addr, input logic [15:0] expected);
		@(posedge adc0_sclk);
		rd_adc <= 3'(adc);
		rd_addr <= 4'(addr);
		@(negedge adc0_sclk);    // The read port is combinational.
		check_value($sformatf("rd_data[%0d][%0d]", adc, addr), 32'(rd_data), 32'(expected));
	endtask

	// Runs one host write from the strobe to the checks on frames and shadow.
	task automatic apply_entry(input stim_t s);
		logic [31:0] count_before [NUM_ADC];
		logic [NUM_ADC-1:0] lanes;
		logic [31:0] frame_exp;
		int cycles;
		logic seen;
		lanes = s.mask[NUM_ADC-1:0];
		frame_exp = {12'b0000_0000_0001, s.addr, s.data};
		for (int i = 0; i < NUM_ADC; i++) begin
			count_before[i] = rx_count[i];
		end
		@(posedge adc0_sclk);
		cmd <= '{mask: s.mask, addr: s.addr, data: s.data};
		cmd_valid <= 1'b1;
		@(posedge adc0_sclk);    // The DUT accepts on this edge.
		cmd_valid <= 1'b0;
		cycles = 0;
		seen = 1'b0;
		while (!seen) begin
			@(negedge adc0_sclk);
			// A write keeps busy high up to and including the done cycle.
			check_value("busy", 32'(busy), 32'(!s.exp_reject));
			seen = done | cmd_reject;
			if (!seen) begin
				@(posedge adc0_sclk);
				cycles++;
				if (s.poke && cycles == 10) begin
					// Would rewrite register 2 everywhere if it got through.
					cmd <= '{mask: 8'h03, addr: 4'h2, data: 16'hdead};
					cmd_valid <= 1'b1;
				end else begin
					cmd_valid <= 1'b0;
				end
			end
		end
		check_value("cmd_reject", 32'(cmd_reject), 32'(s.exp_reject));
		check_value("done", 32'(done), 32'(!s.exp_reject));
		check_value("latency", 32'(cycles + 1), s.exp_reject ? 32'd1 : 32'(DONE_LATENCY));
		@(negedge adc0_sclk);
		check_value("done", 32'(done), 32'd0);    // Both are single pulses.
		check_value("cmd_reject", 32'(cmd_reject), 32'd0);
		check_value("busy", 32'(busy), 32'd0);
		check_value("adc_n_scs", 32'(adc_n_scs), 32'({NUM_ADC{1'b1}}));
		for (int i = 0; i < NUM_ADC; i++) begin
			if (!s.exp_reject && lanes[i]) begin
				check_value($sformatf("frame_count[%0d]", i), rx_count[i], count_before[i] + 1);
				check_value($sformatf("frame[%0d]", i), rx_frame[i], frame_exp);
				check_value($sformatf("bit_count[%0d]", i), rx_bits[i], 32'd32);
				exp_shadow[i][s.addr] = s.data;
			end else begin
				check_value($sformatf("frame_count[%0d]", i), rx_count[i], count_before[i]);
			end
			check_value($sformatf("stray_count[%0d]", i), rx_stray[i], 32'd0);
			read_shadow(i, int'(s.addr), exp_shadow[i][s.addr]);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus and report
	//////////////////////////////////////////////////

	initial begin
		errors = 0;
		checks = 0;
		rng_state = 32'd655;
		reset <= 1'b1;
		cmd <= '0;
		cmd_valid <= 1'b0;
		rd_adc <= '0;
		rd_addr <= '0;
		for (int a = 0; a < NUM_ADC; a++) begin
			for (int r = 0; r < 16; r++) begin
				exp_shadow[a][r] = '0;
			end
		end
		// Each row holds mask, address, data, the random data flag, the expected
		// reject and the busy poke.
		stim[0] = '{8'h01, 4'h3, 16'ha5c3, 1'b0, 1'b0, 1'b0};
		stim[1] = '{8'h02, 4'h3, 16'h1234, 1'b0, 1'b0, 1'b0};
		stim[2] = '{8'h03, 4'h7, 16'h0000, 1'b1, 1'b0, 1'b0};
		stim[3] = '{8'h00, 4'h5, 16'hffff, 1'b0, 1'b1, 1'b0};
		stim[4] = '{8'hf4, 4'h5, 16'hffff, 1'b0, 1'b1, 1'b0};    // Only absent converters.
		stim[5] = '{8'h03, 4'hf, 16'h0000, 1'b1, 1'b0, 1'b1};
		stim[6] = '{8'h01, 4'h7, 16'h0000, 1'b1, 1'b0, 1'b0};
		stim[7] = '{8'h81, 4'h0, 16'h0001, 1'b0, 1'b0, 1'b0};
		stim[8] = '{8'h02, 4'hf, 16'h0000, 1'b1, 1'b0, 1'b0};
		stim[9] = '{8'h08, 4'h1, 16'h5555, 1'b0, 1'b1, 1'b0};
		repeat (2) @(posedge adc0_sclk);
		reset <= 1'b0;
		@(negedge adc0_sclk);
		check_value("adc_n_scs", 32'(adc_n_scs), 32'({NUM_ADC{1'b1}}));
		check_value("adc_sdata", 32'(adc_sdata), 32'd0);
		check_value("busy", 32'(busy), 32'd0);
		check_value("done", 32'(done), 32'd0);
		check_value("cmd_reject", 32'(cmd_reject), 32'd0);
		for (int n = 0; n < NUM_ENTRIES; n++) begin
			if (stim[n].rand_data) begin
				rng_state = xorshift32(rng_state);
				stim[n].data = rng_state[15:0];
			end
			apply_entry(stim[n]);
		end
		// Sweep every register and one converter number past the last.
		for (int a = 0; a <= NUM_ADC; a++) begin
			for (int r = 0; r < 16; r++) begin
				if (a < NUM_ADC) begin
					read_shadow(a, r, exp_shadow[a][r]);
				end else begin
					read_shadow(a, r, 16'h0000);
				end
			end
		end
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge adc0_sclk);
			cycle_count++;
		end
		$display("Timeout after %0d cycles, the run did not reach its end.", cycle_count);
		$display("Test failed");
		$finish;
	end

endmodule

/* files.f */
hw/adc_spi_pkg.sv
hw/cmd_sequencer.sv
hw/serial_lane.sv
hw/shadow_tracker.sv
hw/adc_spi_ctrl.sv
tb/adc_serial_model.sv
tb/tb_adc_spi_ctrl.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --timescale 1ns/100ps
TOP      = tb_adc_spi_ctrl
FILELIST = files.f

BUILD    = obj_dir
LOG      = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Test passed" $(LOG)

lint:
	$(TOOL) --lint-only -Wall --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)
